// File: hw/roce_pkg.sv
`default_nettype none

package roce_pkg;

  // Field widths
  localparam int OPCODE_BITS = 5;
  localparam int QPN_BITS    = 10;
  localparam int VADDR_BITS  = 48;
  localparam int LEN_BITS    = 32;
  localparam int PID_BITS    = 6;
  localparam int VFID_BITS   = 4;
  localparam int DEST_BITS   = 4;
  localparam int STRM_BITS   = 2;

  // Opcode sits in a full 32-bit slot in both engine words
  localparam int OPCODE_SLOT_BITS = 32;

  // Engine command word layout
  localparam int SQ_QPN_OFFS    = OPCODE_SLOT_BITS;
  localparam int SQ_HOST_OFFS   = SQ_QPN_OFFS + QPN_BITS;
  localparam int SQ_LAST_OFFS   = SQ_HOST_OFFS + 1;
  localparam int SQ_LVADDR_OFFS = SQ_LAST_OFFS + 1;
  localparam int SQ_RVADDR_OFFS = SQ_LVADDR_OFFS + VADDR_BITS;
  localparam int SQ_LEN_OFFS    = SQ_RVADDR_OFFS + VADDR_BITS;
  localparam int SQ_BITS        = SQ_LEN_OFFS + LEN_BITS;

  // Engine acknowledgement word layout
  localparam int ACK_QPN_OFFS  = OPCODE_SLOT_BITS;
  localparam int ACK_HOST_OFFS = ACK_QPN_OFFS + QPN_BITS;
  localparam int ACK_DEST_OFFS = ACK_HOST_OFFS + 1;
  localparam int ACK_STRM_OFFS = ACK_DEST_OFFS + DEST_BITS;
  localparam int ACK_LAST_OFFS = ACK_STRM_OFFS + STRM_BITS;
  localparam int ACK_BITS      = ACK_LAST_OFFS + 1;

  // Transmit stream
  localparam int NET_DATA_BITS = 32;
  localparam int CRC_BITS      = 32;

  typedef logic [OPCODE_BITS-1:0]   opcode_t;
  typedef logic [QPN_BITS-1:0]      qpn_t;
  typedef logic [VADDR_BITS-1:0]    vaddr_t;
  typedef logic [LEN_BITS-1:0]      rlen_t;
  typedef logic [PID_BITS-1:0]      pid_t;
  typedef logic [VFID_BITS-1:0]     vfid_t;
  typedef logic [DEST_BITS-1:0]     dest_t;
  typedef logic [STRM_BITS-1:0]     strm_t;
  typedef logic [SQ_BITS-1:0]       sq_word_t;
  typedef logic [ACK_BITS-1:0]      ack_word_t;
  typedef logic [NET_DATA_BITS-1:0] net_data_t;
  typedef logic [CRC_BITS-1:0]      crc_t;

  // Reflected CRC-32 (IEEE 802.3)
  localparam crc_t CRC_POLY = 32'hEDB88320;
  localparam crc_t CRC_INIT = 32'hFFFFFFFF;

  // One beat of CRC, low byte first, each byte LSB first
  function automatic crc_t crc32_step(input crc_t crc, input net_data_t data);
    crc_t c;
    c = crc;
    for (int b = 0; b < NET_DATA_BITS / 8; b++) begin
      c = c ^ crc_t'(data[8*b +: 8]);
      for (int k = 0; k < 8; k++) begin
        c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
      end
    end
    return c;
  endfunction

endpackage

`default_nettype wire

// File: hw/meta_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module meta_fifo import roce_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic    nclk,
  input  wire logic    arst_n,

  // Write side
  input  wire logic    in_valid,
  output logic         in_ready,
  input  wire opcode_t in_opcode,
  input  wire qpn_t    in_qpn,
  input  wire logic    in_host,
  input  wire logic    in_last,
  input  wire vaddr_t  in_lvaddr,
  input  wire vaddr_t  in_rvaddr,
  input  wire rlen_t   in_len,

  // Read side
  output logic         out_valid,
  input  wire logic    out_ready,
  output opcode_t      out_opcode,
  output qpn_t         out_qpn,
  output logic         out_host,
  output logic         out_last,
  output vaddr_t       out_lvaddr,
  output vaddr_t       out_rvaddr,
  output rlen_t        out_len
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Entry storage, one array per field
  opcode_t mem_opcode [FIFO_DEPTH];
  qpn_t    mem_qpn    [FIFO_DEPTH];
  logic    mem_host   [FIFO_DEPTH];
  logic    mem_last   [FIFO_DEPTH];
  vaddr_t  mem_lvaddr [FIFO_DEPTH];
  vaddr_t  mem_rvaddr [FIFO_DEPTH];
  rlen_t   mem_len    [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge nclk) begin
    if (push) begin
      mem_opcode[wr_ptr] <= in_opcode;
      mem_qpn[wr_ptr]    <= in_qpn;
      mem_host[wr_ptr]   <= in_host;
      mem_last[wr_ptr]   <= in_last;
      mem_lvaddr[wr_ptr] <= in_lvaddr;
      mem_rvaddr[wr_ptr] <= in_rvaddr;
      mem_len[wr_ptr]    <= in_len;
    end
  end

  // Head entry straight from storage
  assign out_opcode = mem_opcode[rd_ptr];
  assign out_qpn    = mem_qpn[rd_ptr];
  assign out_host   = mem_host[rd_ptr];
  assign out_last   = mem_last[rd_ptr];
  assign out_lvaddr = mem_lvaddr[rd_ptr];
  assign out_rvaddr = mem_rvaddr[rd_ptr];
  assign out_len    = mem_len[rd_ptr];

endmodule

`default_nettype wire

// File: hw/rdma_flow.sv
`timescale 1ns/1ps
`default_nettype none

module rdma_flow import roce_pkg::*; #(
  parameter int N_OUTSTANDING = 4,
  parameter int FIFO_DEPTH    = 4
) (
  input  wire logic      nclk,
  input  wire logic      arst_n,

  // User send queue
  input  wire logic      sq_valid,
  output logic           sq_ready,
  input  wire opcode_t   sq_opcode,
  input  wire qpn_t      sq_qpn,
  input  wire logic      sq_host,
  input  wire logic      sq_last,
  input  wire vaddr_t    sq_lvaddr,
  input  wire vaddr_t    sq_rvaddr,
  input  wire rlen_t     sq_len,

  // Engine command
  output logic           eng_sq_valid,
  input  wire logic      eng_sq_ready,
  output sq_word_t       eng_sq_data,

  // Engine acknowledgement
  input  wire logic      eng_ack_valid,
  output logic           eng_ack_ready,
  input  wire ack_word_t eng_ack_data,

  // User acknowledgement
  output logic           ack_valid,
  input  wire logic      ack_ready,
  output opcode_t        ack_opcode,
  output pid_t           ack_pid,
  output vfid_t          ack_vfid,
  output logic           ack_host,
  output dest_t          ack_dest,
  output strm_t          ack_strm,
  output logic           ack_last
);

  localparam int CNT_W = $clog2(N_OUTSTANDING + 1);

  // FIFO head
  logic    head_valid;
  logic    head_ready;
  opcode_t head_opcode;
  qpn_t    head_qpn;
  logic    head_host;
  logic    head_last;
  vaddr_t  head_lvaddr;
  vaddr_t  head_rvaddr;
  rlen_t   head_len;

  // Outstanding last-flagged requests
  logic [CNT_W-1:0] outstanding;
  logic             credit_free;
  logic             head_go;
  logic             cmd_done;
  logic             ack_done;

  meta_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) meta_fifo_inst (
    .nclk      (nclk),
    .arst_n    (arst_n),
    .in_valid  (sq_valid),
    .in_ready  (sq_ready),
    .in_opcode (sq_opcode),
    .in_qpn    (sq_qpn),
    .in_host   (sq_host),
    .in_last   (sq_last),
    .in_lvaddr (sq_lvaddr),
    .in_rvaddr (sq_rvaddr),
    .in_len    (sq_len),
    .out_valid (head_valid),
    .out_ready (head_ready),
    .out_opcode(head_opcode),
    .out_qpn   (head_qpn),
    .out_host  (head_host),
    .out_last  (head_last),
    .out_lvaddr(head_lvaddr),
    .out_rvaddr(head_rvaddr),
    .out_len   (head_len)
  );

  // Only last-flagged heads need a credit
  assign credit_free  = (outstanding != CNT_W'(N_OUTSTANDING));
  assign head_go      = !head_last || credit_free;
  assign eng_sq_valid = head_valid && head_go;
  assign head_ready   = eng_sq_ready && head_go;

  assign cmd_done = eng_sq_valid && eng_sq_ready && head_last;
  assign ack_done = eng_ack_valid && ack_ready && ack_last;

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding <= '0;
    end else if (cmd_done && !ack_done) begin
      outstanding <= outstanding + 1'b1;
    end else if (ack_done && !cmd_done && outstanding != '0) begin
      // Stray ack with nothing outstanding is ignored
      outstanding <= outstanding - 1'b1;
    end
  end

  // Pack head into engine command word
  always_comb begin
    eng_sq_data                               = '0;
    eng_sq_data[0 +: OPCODE_BITS]             = head_opcode;
    eng_sq_data[SQ_QPN_OFFS +: QPN_BITS]      = head_qpn;
    eng_sq_data[SQ_HOST_OFFS]                 = head_host;
    eng_sq_data[SQ_LAST_OFFS]                 = head_last;
    eng_sq_data[SQ_LVADDR_OFFS +: VADDR_BITS] = head_lvaddr;
    eng_sq_data[SQ_RVADDR_OFFS +: VADDR_BITS] = head_rvaddr;
    eng_sq_data[SQ_LEN_OFFS +: LEN_BITS]      = head_len;
  end

  // Ack path is combinational, user ready goes straight back
  assign ack_valid     = eng_ack_valid;
  assign eng_ack_ready = ack_ready;

  // pid is the low QPN bits, vfid the next ones
  assign ack_opcode = eng_ack_data[0 +: OPCODE_BITS];
  assign ack_pid    = eng_ack_data[ACK_QPN_OFFS +: PID_BITS];
  assign ack_vfid   = eng_ack_data[ACK_QPN_OFFS + PID_BITS +: VFID_BITS];
  assign ack_host   = eng_ack_data[ACK_HOST_OFFS];
  assign ack_dest   = eng_ack_data[ACK_DEST_OFFS +: DEST_BITS];
  assign ack_strm   = eng_ack_data[ACK_STRM_OFFS +: STRM_BITS];
  assign ack_last   = eng_ack_data[ACK_LAST_OFFS];

endmodule

`default_nettype wire

// File: hw/icrc.sv
`timescale 1ns/1ps
`default_nettype none

module icrc import roce_pkg::*; (
  input  wire logic      nclk,
  input  wire logic      arst_n,

  // From engine
  input  wire logic      eng_tx_valid,
  output logic           eng_tx_ready,
  input  wire net_data_t eng_tx_data,
  input  wire logic      eng_tx_last,

  // To network
  output logic           tx_valid,
  input  wire logic      tx_ready,
  output net_data_t      tx_data,
  output logic           tx_last
);

  typedef enum logic {
    PASS,
    TAIL
  } state_t;

  state_t state;
  state_t state_nxt;
  crc_t   crc_q;
  crc_t   crc_nxt;
  logic   beat_in;
  logic   tail_out;

  // Engine beat accepted
  assign beat_in  = (state == PASS) && eng_tx_valid && tx_ready;
  // CRC beat accepted by network
  assign tail_out = (state == TAIL) && tx_ready;

  // Output mux
  always_comb begin
    if (state == TAIL) begin
      tx_valid     = 1'b1;
      tx_data      = ~crc_q;
      tx_last      = 1'b1;
      eng_tx_ready = 1'b0;
    end else begin
      // Data beats never carry last toward the network
      tx_valid     = eng_tx_valid;
      tx_data      = eng_tx_data;
      tx_last      = 1'b0;
      eng_tx_ready = tx_ready;
    end
  end

  // Next state and CRC
  always_comb begin
    state_nxt = state;
    crc_nxt   = crc_q;
    case (state)
      PASS: begin
        if (beat_in) begin
          crc_nxt = crc32_step(crc_q, eng_tx_data);
          if (eng_tx_last) begin
            state_nxt = TAIL;
          end
        end
      end
      TAIL: begin
        // Ready for next packet
        if (tail_out) begin
          crc_nxt   = CRC_INIT;
          state_nxt = PASS;
        end
      end
      default: begin
        state_nxt = PASS;
        crc_nxt   = CRC_INIT;
      end
    endcase
  end

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= PASS;
      crc_q <= CRC_INIT;
    end else begin
      state <= state_nxt;
      crc_q <= crc_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hw/roce_stack.sv
`timescale 1ns/1ps
`default_nettype none

module roce_stack import roce_pkg::*; #(
  parameter int N_OUTSTANDING = 4,
  parameter int FIFO_DEPTH    = 4
) (
  input  wire logic      nclk,
  input  wire logic      arst_n,

  // User send queue
  input  wire logic      sq_valid,
  output logic           sq_ready,
  input  wire opcode_t   sq_opcode,
  input  wire qpn_t      sq_qpn,
  input  wire logic      sq_host,
  input  wire logic      sq_last,
  input  wire vaddr_t    sq_lvaddr,
  input  wire vaddr_t    sq_rvaddr,
  input  wire rlen_t     sq_len,

  // User acknowledgement
  output logic           ack_valid,
  input  wire logic      ack_ready,
  output opcode_t        ack_opcode,
  output pid_t           ack_pid,
  output vfid_t          ack_vfid,
  output logic           ack_host,
  output dest_t          ack_dest,
  output strm_t          ack_strm,
  output logic           ack_last,

  // Engine flat command and ack ports
  output logic           eng_sq_valid,
  input  wire logic      eng_sq_ready,
  output sq_word_t       eng_sq_data,
  input  wire logic      eng_ack_valid,
  output logic           eng_ack_ready,
  input  wire ack_word_t eng_ack_data,

  // Engine transmit stream
  input  wire logic      eng_tx_valid,
  output logic           eng_tx_ready,
  input  wire net_data_t eng_tx_data,
  input  wire logic      eng_tx_last,

  // Network transmit stream
  output logic           tx_valid,
  input  wire logic      tx_ready,
  output net_data_t      tx_data,
  output logic           tx_last
);

  // Credit flow control, command packing, ack decode
  rdma_flow #(
    .N_OUTSTANDING(N_OUTSTANDING),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) rdma_flow_inst (
    .nclk         (nclk),
    .arst_n       (arst_n),
    .sq_valid     (sq_valid),
    .sq_ready     (sq_ready),
    .sq_opcode    (sq_opcode),
    .sq_qpn       (sq_qpn),
    .sq_host      (sq_host),
    .sq_last      (sq_last),
    .sq_lvaddr    (sq_lvaddr),
    .sq_rvaddr    (sq_rvaddr),
    .sq_len       (sq_len),
    .eng_sq_valid (eng_sq_valid),
    .eng_sq_ready (eng_sq_ready),
    .eng_sq_data  (eng_sq_data),
    .eng_ack_valid(eng_ack_valid),
    .eng_ack_ready(eng_ack_ready),
    .eng_ack_data (eng_ack_data),
    .ack_valid    (ack_valid),
    .ack_ready    (ack_ready),
    .ack_opcode   (ack_opcode),
    .ack_pid      (ack_pid),
    .ack_vfid     (ack_vfid),
    .ack_host     (ack_host),
    .ack_dest     (ack_dest),
    .ack_strm     (ack_strm),
    .ack_last     (ack_last)
  );

  // Invariant CRC on outgoing packets
  icrc icrc_inst (
    .nclk        (nclk),
    .arst_n      (arst_n),
    .eng_tx_valid(eng_tx_valid),
    .eng_tx_ready(eng_tx_ready),
    .eng_tx_data (eng_tx_data),
    .eng_tx_last (eng_tx_last),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready),
    .tx_data     (tx_data),
    .tx_last     (tx_last)
  );

endmodule

`default_nettype wire

// File: tests/roce_stack_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// Valid/ready checker for one outgoing stream plus an optional level bound
module roce_stack_asserts #(
  parameter int W           = 32,
  parameter bit CHECK_LEVEL = 1'b1
) (
  input wire logic         nclk,
  input wire logic         arst_n,
  input wire logic         valid,
  input wire logic         ready,
  input wire logic [W-1:0] data,
  input wire logic [31:0]  level,
  input wire logic [31:0]  limit
);

  // Offered beat stays put until taken
  hold_until_taken: assert property (@(posedge nclk) disable iff (!arst_n)
    valid && !ready |=> valid && $stable(data))
    else $error("valid dropped or data changed before the transfer");

  // Nothing offered while in reset
  quiet_in_reset: assert property (@(posedge nclk) !arst_n |-> !valid)
    else $error("valid high while reset is applied");

  // Outstanding requests within the credit limit
  if (CHECK_LEVEL) begin : g_level
    level_bound: assert property (@(posedge nclk) disable iff (!arst_n) level <= limit)
      else $error("outstanding count above its limit");
  end

endmodule

// Command side, credit count against N_OUTSTANDING
bind rdma_flow roce_stack_asserts #(
  .W(roce_pkg::SQ_BITS)
) flow_asserts (
  .nclk  (nclk),
  .arst_n(arst_n),
  .valid (eng_sq_valid),
  .ready (eng_sq_ready),
  .data  (eng_sq_data),
  .level (32'(outstanding)),
  .limit (32'(N_OUTSTANDING))
);

// Network side, last flag checked with the data
bind icrc roce_stack_asserts #(
  .W          (roce_pkg::NET_DATA_BITS + 1),
  .CHECK_LEVEL(1'b0)
) tx_asserts (
  .nclk  (nclk),
  .arst_n(arst_n),
  .valid (tx_valid),
  .ready (tx_ready),
  .data  ({tx_last, tx_data}),
  .level (32'd0),
  .limit (32'd0)
);

`default_nettype wire

// File: tests/roce_stack_tb.sv
`timescale 1ns/1ps
`default_nettype none

module roce_stack_tb import roce_pkg::*; ();

  localparam int N_OUT      = 4;
  localparam int DEPTH      = 4;
  localparam int N_ROWS     = 20;
  localparam int MAX_CYCLES = 40 * N_ROWS + 200;

  typedef enum logic [1:0] {K_CMD, K_ACK, K_PKT} kind_t;

  // One table row: stimulus fields plus expected state after the row
  typedef struct {
    kind_t   kind;
    opcode_t opcode;
    qpn_t    qpn;
    logic    host;
    logic    last;
    vaddr_t  lvaddr;
    vaddr_t  rvaddr;
    rlen_t   len;
    dest_t   dest;
    strm_t   strm;
    int      beats;
    logic    stall;
    int      exp_eng;
    logic    exp_rdy;
  } row_t;

  logic      nclk = 1'b0;
  logic      arst_n;
  logic      sq_valid;
  logic      sq_ready;
  opcode_t   sq_opcode;
  qpn_t      sq_qpn;
  logic      sq_host;
  logic      sq_last;
  vaddr_t    sq_lvaddr;
  vaddr_t    sq_rvaddr;
  rlen_t     sq_len;
  logic      ack_valid;
  logic      ack_ready;
  opcode_t   ack_opcode;
  pid_t      ack_pid;
  vfid_t     ack_vfid;
  logic      ack_host;
  dest_t     ack_dest;
  strm_t     ack_strm;
  logic      ack_last;
  logic      eng_sq_valid;
  logic      eng_sq_ready;
  sq_word_t  eng_sq_data;
  logic      eng_ack_valid;
  logic      eng_ack_ready;
  ack_word_t eng_ack_data;
  logic      eng_tx_valid;
  logic      eng_tx_ready;
  net_data_t eng_tx_data;
  logic      eng_tx_last;
  logic      tx_valid;
  logic      tx_ready;
  net_data_t tx_data;
  logic      tx_last;

  row_t        rows [N_ROWS];
  int          n_rows = 0;
  int          seed = 25192;
  int          cycles = 0;
  int          errors = 0;
  int          eng_count = 0;
  logic        stall_on = 1'b0;
  logic [31:0] stall_mask = '1;
  // Rows sent but not yet seen by the engine, then rows the engine holds
  int          exp_sq [$];
  int          pend_ack [$];
  net_data_t   exp_beat [$];
  logic        exp_last [$];

  roce_stack #(
    .N_OUTSTANDING(N_OUT),
    .FIFO_DEPTH   (DEPTH)
  ) roce_stack_inst (
    .nclk(nclk), .arst_n(arst_n),
    .sq_valid(sq_valid), .sq_ready(sq_ready), .sq_opcode(sq_opcode), .sq_qpn(sq_qpn),
    .sq_host(sq_host), .sq_last(sq_last), .sq_lvaddr(sq_lvaddr), .sq_rvaddr(sq_rvaddr),
    .sq_len(sq_len),
    .ack_valid(ack_valid), .ack_ready(ack_ready), .ack_opcode(ack_opcode),
    .ack_pid(ack_pid), .ack_vfid(ack_vfid), .ack_host(ack_host), .ack_dest(ack_dest),
    .ack_strm(ack_strm), .ack_last(ack_last),
    .eng_sq_valid(eng_sq_valid), .eng_sq_ready(eng_sq_ready), .eng_sq_data(eng_sq_data),
    .eng_ack_valid(eng_ack_valid), .eng_ack_ready(eng_ack_ready),
    .eng_ack_data(eng_ack_data),
    .eng_tx_valid(eng_tx_valid), .eng_tx_ready(eng_tx_ready), .eng_tx_data(eng_tx_data),
    .eng_tx_last(eng_tx_last),
    .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data), .tx_last(tx_last)
  );

  always #4 nclk = ~nclk;

  task automatic report_fail(input string msg);
    errors++;
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic add_cmd(input opcode_t op, input qpn_t qpn, input logic host,
                         input logic last, input vaddr_t lva, input vaddr_t rva,
                         input rlen_t len, input int exp_eng, input logic exp_rdy);
    rows[n_rows] = '{K_CMD, op, qpn, host, last, lva, rva, len, '0, '0, 0, 1'b0,
                     exp_eng, exp_rdy};
    n_rows++;
  endtask

  task automatic add_ack(input dest_t dest, input strm_t strm, input int exp_eng);
    rows[n_rows] = '{K_ACK, '0, '0, 1'b0, 1'b0, '0, '0, '0, dest, strm, 0, 1'b0,
                     exp_eng, 1'b1};
    n_rows++;
  endtask

  task automatic add_pkt(input int beats, input logic stall, input int exp_eng);
    rows[n_rows] = '{K_PKT, '0, '0, 1'b0, 1'b0, '0, '0, '0, '0, '0, beats, stall,
                     exp_eng, 1'b1};
    n_rows++;
  endtask

  // Four credits used, a non-last command slips through, four more fill the FIFO
  task automatic load_table();
    add_cmd(5'h04, 10'h3a5, 1'b1, 1'b1, 48'h0000_1000_0040, 48'h7f00_0000_0100, 32'h40, 1, 1);
    add_cmd(5'h06, 10'h041, 1'b0, 1'b1, 48'h0000_2000_0000, 48'h7f00_0000_2000, 32'h80, 2, 1);
    add_cmd(5'h0a, 10'h2c7, 1'b1, 1'b1, 48'hffff_0000_1234, 48'h0001_0002_0003, 32'h1, 3, 1);
    add_cmd(5'h04, 10'h1ff, 1'b1, 1'b1, 48'h8000_0000_0000, 48'h0000_0000_0001, 32'hffff, 4, 1);
    add_cmd(5'h06, 10'h012, 1'b0, 1'b0, 48'h1234_5678_9abc, 48'hcba9_8765_4321, 32'h10, 5, 1);
    add_cmd(5'h0a, 10'h300, 1'b1, 1'b1, 48'h0000_0000_0f00, 48'h0000_0000_f000, 32'h200, 5, 1);
    add_cmd(5'h1f, 10'h0aa, 1'b0, 1'b1, 48'h5555_aaaa_5555, 48'haaaa_5555_aaaa, 32'h7, 5, 1);
    add_cmd(5'h01, 10'h155, 1'b1, 1'b1, 48'h0000_0001_0000, 48'h0000_0002_0000, 32'h1000, 5, 1);
    add_cmd(5'h11, 10'h2aa, 1'b1, 1'b1, 48'h0bad_f00d_0000, 48'h0000_0bad_f00d, 32'h3c, 5, 0);
    // Each last-flagged ack frees exactly one held command
    add_ack(4'h3, 2'h1, 6);
    add_ack(4'ha, 2'h2, 7);
    add_ack(4'h0, 2'h3, 8);
    add_ack(4'hf, 2'h0, 9);
    add_ack(4'h5, 2'h1, 9);
    add_cmd(5'h08, 10'h3ff, 1'b0, 1'b1, 48'h0000_dead_beef, 48'hbeef_dead_0000, 32'h99, 9, 1);
    add_ack(4'h9, 2'h2, 10);
    add_pkt(1, 1'b0, 10);
    add_pkt(5, 1'b0, 10);
    add_pkt(4, 1'b1, 10);
    add_pkt(7, 1'b1, 10);
  endtask

  // Command word from the top field down
  function automatic sq_word_t pack_ref(input int i);
    return {rows[i].len, rows[i].rvaddr, rows[i].lvaddr, rows[i].last, rows[i].host,
            rows[i].qpn, 27'b0, rows[i].opcode};
  endfunction

  // Bit-serial reflected CRC-32, word bits LSB first
  function automatic crc_t crc_ref(input crc_t crc, input net_data_t d);
    crc_t c;
    logic fb;
    c = crc;
    for (int k = 0; k < 32; k++) begin
      fb = c[0] ^ d[k];
      c = c >> 1;
      if (fb) begin
        c = c ^ CRC_POLY;
      end
    end
    return c;
  endfunction

  task automatic check_sq(input sq_word_t got, input sq_word_t exp);
    if (got !== exp) begin
      report_fail($sformatf("mismatch at %0t: eng_sq_data %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_ack(input opcode_t op, input pid_t pid, input vfid_t vfid,
                           input logic host, input dest_t dest, input strm_t strm,
                           input logic last, input opcode_t e_op, input pid_t e_pid,
                           input vfid_t e_vfid, input logic e_host, input dest_t e_dest,
                           input strm_t e_strm, input logic e_last);
    if ({op, pid, vfid, host, dest, strm, last} !==
        {e_op, e_pid, e_vfid, e_host, e_dest, e_strm, e_last}) begin
      report_fail($sformatf("mismatch at %0t: ack op/pid/vfid/host/dest/strm/last %h %h %h %b %h %h %b, expected %h %h %h %b %h %h %b",
                            $time, op, pid, vfid, host, dest, strm, last,
                            e_op, e_pid, e_vfid, e_host, e_dest, e_strm, e_last));
    end
  endtask

  task automatic check_beat(input net_data_t got, input net_data_t exp,
                            input logic got_last, input logic exp_last);
    if (got !== exp || got_last !== exp_last) begin
      report_fail($sformatf("mismatch at %0t: tx beat %h last %b, expected %h last %b",
                            $time, got, got_last, exp, exp_last));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      report_fail($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic send_cmd(input int i);
    @(posedge nclk);
    #1;
    sq_valid  = 1'b1;
    sq_opcode = rows[i].opcode;
    sq_qpn    = rows[i].qpn;
    sq_host   = rows[i].host;
    sq_last   = rows[i].last;
    sq_lvaddr = rows[i].lvaddr;
    sq_rvaddr = rows[i].rvaddr;
    sq_len    = rows[i].len;
    do @(negedge nclk); while (!sq_ready);
    exp_sq.push_back(i);
    @(posedge nclk);
    #1;
    sq_valid = 1'b0;
  endtask

  // Engine returns the ack of its oldest held command
  task automatic send_ack(input int i);
    int idx;
    if (pend_ack.size() == 0) begin
      report_fail("ack row reached with no command held by the engine model");
    end else begin
      idx = pend_ack.pop_front();
      @(posedge nclk);
      #1;
      eng_ack_valid = 1'b1;
      eng_ack_data  = {rows[idx].last, rows[i].strm, rows[i].dest, rows[idx].host,
                       rows[idx].qpn, 27'b0, rows[idx].opcode};
      do @(negedge nclk); while (!eng_ack_ready);
      if (!ack_valid) begin
        report_fail("ack_valid stayed low while the engine offered an ack");
      end
      check_ack(ack_opcode, ack_pid, ack_vfid, ack_host, ack_dest, ack_strm, ack_last,
                rows[idx].opcode, rows[idx].qpn[5:0], rows[idx].qpn[9:6], rows[idx].host,
                rows[i].dest, rows[i].strm, rows[idx].last);
      @(posedge nclk);
      #1;
      eng_ack_valid = 1'b0;
    end
  endtask

  task automatic send_pkt(input int i);
    net_data_t d;
    crc_t      crc;
    crc        = CRC_INIT;
    // Sparse stall pattern, at least one ready cycle in four
    stall_mask = $random(seed) | 32'h1111_1111;
    stall_on   = rows[i].stall;
    for (int b = 0; b < rows[i].beats; b++) begin
      d   = $random(seed);
      crc = crc_ref(crc, d);
      exp_beat.push_back(d);
      exp_last.push_back(1'b0);
      @(posedge nclk);
      #1;
      eng_tx_valid = 1'b1;
      eng_tx_data  = d;
      eng_tx_last  = (b == rows[i].beats - 1);
      do @(negedge nclk); while (!eng_tx_ready);
    end
    exp_beat.push_back(~crc);
    exp_last.push_back(1'b1);
    @(posedge nclk);
    #1;
    eng_tx_valid = 1'b0;
    eng_tx_last  = 1'b0;
    while (exp_beat.size() != 0) begin
      @(negedge nclk);
    end
    stall_on = 1'b0;
  endtask

  // Network side ready, stalled from the mask on packet rows
  always @(posedge nclk) begin
    #1;
    tx_ready = stall_on ? stall_mask[cycles[4:0]] : 1'b1;
  end

  // Engine command ready, low one cycle in three
  always @(posedge nclk) begin
    #1;
    eng_sq_ready = (cycles % 3) != 0;
  end

  // Engine model, commands sampled before the transfer edge
  always @(negedge nclk) begin
    int idx;
    if (arst_n && eng_sq_valid && eng_sq_ready) begin
      if (exp_sq.size() == 0) begin
        report_fail("engine received a command that was never sent");
      end else begin
        idx = exp_sq.pop_front();
        check_sq(eng_sq_data, pack_ref(idx));
        pend_ack.push_back(idx);
        eng_count++;
      end
    end
  end

  // Network monitor
  always @(negedge nclk) begin
    net_data_t want;
    logic      want_last;
    // Engine stream is held off while the CRC beat is out
    if (arst_n && tx_valid && tx_last && eng_tx_ready) begin
      report_fail("engine side was offered ready during the CRC beat");
    end
    if (arst_n && tx_valid && tx_ready) begin
      if (exp_beat.size() == 0) begin
        report_fail("network received a beat that was not expected");
      end else begin
        want      = exp_beat.pop_front();
        want_last = exp_last.pop_front();
        check_beat(tx_data, want, tx_last, want_last);
      end
    end
  end

  always @(posedge nclk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      report_fail($sformatf("timeout after %0d cycles, a handshake never completed", cycles));
    end
  end

  initial begin
    arst_n        = 1'b0;
    sq_valid      = 1'b0;
    sq_opcode     = '0;
    sq_qpn        = '0;
    sq_host       = 1'b0;
    sq_last       = 1'b0;
    sq_lvaddr     = '0;
    sq_rvaddr     = '0;
    sq_len        = '0;
    ack_ready     = 1'b1;
    eng_sq_ready  = 1'b1;
    eng_ack_valid = 1'b0;
    eng_ack_data  = '0;
    eng_tx_valid  = 1'b0;
    eng_tx_data   = '0;
    eng_tx_last   = 1'b0;
    tx_ready      = 1'b1;
    load_table();
    repeat (4) @(posedge nclk);
    #1;
    arst_n = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      case (rows[i].kind)
        K_CMD:   send_cmd(i);
        K_ACK:   send_ack(i);
        default: send_pkt(i);
      endcase
      // Settle, then state sampled away from the clock edge
      repeat (3) @(negedge nclk);
      check_count(eng_count, rows[i].exp_eng, "engine command count");
      check_count(int'(sq_ready), int'(rows[i].exp_rdy), "sq_ready");
    end
    if (errors == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      report_fail("errors were recorded before the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
hw/roce_pkg.sv
hw/meta_fifo.sv
hw/rdma_flow.sv
hw/icrc.sv
hw/roce_stack.sv
tests/roce_stack_asserts.sv
tests/roce_stack_tb.sv

// File: Makefile
SRCS := $(wildcard hw/*.sv tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vroce_stack_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module roce_stack_tb \
		-f filelist.f -o Vroce_stack_tb

run: obj_dir/Vroce_stack_tb
	./obj_dir/Vroce_stack_tb > sim.log 2>&1; cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
